// File: logic/experiar_config.svh
`ifndef EXPERIAR_CONFIG_SVH
`define EXPERIAR_CONFIG_SVH

// Bus widths
`define WB_DATA_WIDTH     32
`define WB_ADDR_WIDTH     28
`define SLAVE_ADDR_WIDTH  24
`define WB_SEL_WIDTH      4

// One SRAM bank
`define SRAM_ADDR_WIDTH   9
`define SRAM_DEPTH        512

`define GPIO_WIDTH        32
`define CARAVEL_IRQ_WIDTH 4

// Regions decoded from address bits 27 to 24
`define REGION_MEM0       4'h0
`define REGION_MEM1       4'h1
`define REGION_GPIO       4'h3

// GPIO byte offsets
`define GPIO_OUT_OFS      8'h00
`define GPIO_OE_OFS       8'h04
`define GPIO_IN_OFS       8'h08
`define GPIO_IRQ_OFS      8'h0C

`endif

// File: logic/experiar_pkg.sv
`include "experiar_config.svh"

package experiar_pkg;

	// Bus side
	typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;
	typedef logic [`WB_ADDR_WIDTH-1:0] wb_addr_t;
	typedef logic [`SLAVE_ADDR_WIDTH-1:0] slave_addr_t;
	typedef logic [`WB_SEL_WIDTH-1:0] wb_sel_t;

	// Word address inside one SRAM bank
	typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;

	// Pad vector
	typedef logic [`GPIO_WIDTH-1:0] gpio_t;

	// Upper address nibble above the slave window
	typedef logic [`WB_ADDR_WIDTH-`SLAVE_ADDR_WIDTH-1:0] region_t;

	// Decoded target of a request
	typedef enum logic [1:0] {
		SLAVE_MEM0,
		SLAVE_MEM1,
		SLAVE_GPIO,
		SLAVE_NONE
	} slave_sel_t;

endpackage

// File: logic/sram_32x512.sv
`timescale 1ns/1ps

`include "experiar_config.svh"

module sram_32x512 (
	input  logic                     clk_i,
	input  logic                     csb_i,
	input  logic                     web_i,
	input  experiar_pkg::wb_sel_t    wmask_i,
	input  experiar_pkg::sram_addr_t addr_i,
	input  experiar_pkg::wb_data_t   din_i,
	output experiar_pkg::wb_data_t   dout_o
);

	import experiar_pkg::*;

	wb_data_t mem [0:`SRAM_DEPTH-1];

	always_ff @(posedge clk_i) begin
		if (!csb_i) begin
			// Read returns the old word, even on a write
			dout_o <= mem[addr_i];
			if (!web_i) begin
				for (int i = 0; i < `WB_SEL_WIDTH; i++) begin
					if (wmask_i[i]) begin
						mem[addr_i][8*i +: 8] <= din_i[8*i +: 8];
					end
				end
			end
		end
	end

endmodule

// File: logic/local_memory.sv
`timescale 1ns/1ps

`include "experiar_config.svh"

module local_memory (
	input  logic                      wb_clk_i,
	input  logic                      rst_n_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  experiar_pkg::wb_sel_t     wb_sel_i,
	input  experiar_pkg::wb_data_t    wb_data_i,
	input  experiar_pkg::slave_addr_t wb_adr_i,
	output logic                      wb_ack_o,
	output experiar_pkg::wb_data_t    wb_data_o
);

	import experiar_pkg::*;

	sram_addr_t word_addr;
	logic       bank_sel;
	logic       bank_sel_q;
	logic [1:0] bank_csb;
	logic       bank_web;
	wb_data_t   bank0_dout;
	wb_data_t   bank1_dout;

	// Bit 11 picks the bank, bits 10 to 2 the word
	assign bank_sel  = wb_adr_i[`SRAM_ADDR_WIDTH+2];
	assign word_addr = wb_adr_i[`SRAM_ADDR_WIDTH+1:2];

	// Macro controls are active low
	assign bank_csb[0] = ~(wb_stb_i & ~bank_sel);
	assign bank_csb[1] = ~(wb_stb_i & bank_sel);
	assign bank_web    = ~wb_we_i;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= wb_stb_i;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		bank_sel_q <= bank_sel;
	end

	sram_32x512 u_bank0 (
		.clk_i   (wb_clk_i),
		.csb_i   (bank_csb[0]),
		.web_i   (bank_web),
		.wmask_i (wb_sel_i),
		.addr_i  (word_addr),
		.din_i   (wb_data_i),
		.dout_o  (bank0_dout)
	);

	sram_32x512 u_bank1 (
		.clk_i   (wb_clk_i),
		.csb_i   (bank_csb[1]),
		.web_i   (bank_web),
		.wmask_i (wb_sel_i),
		.addr_i  (word_addr),
		.din_i   (wb_data_i),
		.dout_o  (bank1_dout)
	);

	// Bank output lines up with the ack
	assign wb_data_o = bank_sel_q ? bank1_dout : bank0_dout;

endmodule

// File: logic/gpio_peripheral.sv
`timescale 1ns/1ps

`include "experiar_config.svh"

module gpio_peripheral (
	input  logic                      wb_clk_i,
	input  logic                      rst_n_i,
	input  logic                      wb_stb_i,
	input  logic                      wb_we_i,
	input  experiar_pkg::wb_sel_t     wb_sel_i,
	input  experiar_pkg::wb_data_t    wb_data_i,
	input  experiar_pkg::slave_addr_t wb_adr_i,
	input  experiar_pkg::gpio_t       gpio_in_i,
	output logic                      wb_ack_o,
	output experiar_pkg::wb_data_t    wb_data_o,
	output experiar_pkg::gpio_t       gpio_out_o,
	output experiar_pkg::gpio_t       gpio_oeb_o,
	output logic                      gpio_irq_o
);

	import experiar_pkg::*;

	logic [7:0] reg_ofs;
	logic       write_en;
	wb_data_t   byte_mask;
	wb_data_t   read_word;
	gpio_t      out_q;
	gpio_t      oe_q;
	gpio_t      pending_q;
	gpio_t      sync1_q;
	gpio_t      sync2_q;
	gpio_t      prev_q;
	gpio_t      rise;
	gpio_t      irq_clear;

	assign reg_ofs  = {wb_adr_i[7:2], 2'b00};
	assign write_en = wb_stb_i & wb_we_i;

	// Expand byte selects to bit mask
	always_comb begin
		for (int i = 0; i < `WB_SEL_WIDTH; i++) begin
			byte_mask[8*i +: 8] = {8{wb_sel_i[i]}};
		end
	end

	assign rise = sync2_q & ~prev_q;
	assign irq_clear = (write_en && reg_ofs == `GPIO_IRQ_OFS) ? (wb_data_i & byte_mask) : '0;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			wb_ack_o  <= 1'b0;
			out_q     <= '0;
			oe_q      <= '0;
			pending_q <= '0;
			sync1_q   <= '0;
			sync2_q   <= '0;
			prev_q    <= '0;
		end else begin
			wb_ack_o <= wb_stb_i;
			sync1_q  <= gpio_in_i;
			sync2_q  <= sync1_q;
			prev_q   <= sync2_q;
			// a new edge wins over a clear in the same cycle
			pending_q <= (pending_q & ~irq_clear) | rise;
			if (write_en && reg_ofs == `GPIO_OUT_OFS) begin
				out_q <= (out_q & ~byte_mask) | (wb_data_i & byte_mask);
			end
			if (write_en && reg_ofs == `GPIO_OE_OFS) begin
				oe_q <= (oe_q & ~byte_mask) | (wb_data_i & byte_mask);
			end
		end
	end

	always_comb begin
		case (reg_ofs)
			`GPIO_OUT_OFS: read_word = out_q;
			`GPIO_OE_OFS:  read_word = oe_q;
			`GPIO_IN_OFS:  read_word = sync2_q;
			`GPIO_IRQ_OFS: read_word = pending_q;
			default:       read_word = '0;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		wb_data_o <= read_word;
	end

	assign gpio_out_o = out_q;
	// Pad enable is active low
	assign gpio_oeb_o = ~oe_q;
	assign gpio_irq_o = |pending_q;

endmodule

// File: logic/wishbone_interconnect.sv
`timescale 1ns/1ps

`include "experiar_config.svh"

module wishbone_interconnect (
	input  logic                      wb_clk_i,
	input  logic                      rst_n_i,

	// Master side
	input  logic                      m_cyc_i,
	input  logic                      m_stb_i,
	input  logic                      m_we_i,
	input  experiar_pkg::wb_sel_t     m_sel_i,
	input  experiar_pkg::wb_data_t    m_data_i,
	input  experiar_pkg::wb_addr_t    m_adr_i,
	output logic                      m_ack_o,
	output logic                      m_error_o,
	output experiar_pkg::wb_data_t    m_data_o,

	// Per-slave strobe and response
	output logic                      mem0_stb_o,
	input  logic                      mem0_ack_i,
	input  experiar_pkg::wb_data_t    mem0_data_i,
	output logic                      mem1_stb_o,
	input  logic                      mem1_ack_i,
	input  experiar_pkg::wb_data_t    mem1_data_i,
	output logic                      gpio_stb_o,
	input  logic                      gpio_ack_i,
	input  experiar_pkg::wb_data_t    gpio_data_i,

	// Request fields shared by all slaves
	output logic                      s_we_o,
	output experiar_pkg::wb_sel_t     s_sel_o,
	output experiar_pkg::wb_data_t    s_data_o,
	output experiar_pkg::slave_addr_t s_adr_o
);

	import experiar_pkg::*;

	region_t    region;
	slave_sel_t req_sel;
	slave_sel_t resp_sel;
	logic       req_valid;
	logic       resp_valid;
	logic       resp_ack;

	assign req_valid = m_cyc_i & m_stb_i;
	assign region = m_adr_i[`WB_ADDR_WIDTH-1:`SLAVE_ADDR_WIDTH];

	always_comb begin
		case (region)
			`REGION_MEM0: req_sel = SLAVE_MEM0;
			`REGION_MEM1: req_sel = SLAVE_MEM1;
			`REGION_GPIO: req_sel = SLAVE_GPIO;
			default:      req_sel = SLAVE_NONE;
		endcase
	end

	// Only the decoded slave sees the strobe
	assign mem0_stb_o = req_valid & (req_sel == SLAVE_MEM0);
	assign mem1_stb_o = req_valid & (req_sel == SLAVE_MEM1);
	assign gpio_stb_o = req_valid & (req_sel == SLAVE_GPIO);

	assign s_we_o   = m_we_i;
	assign s_sel_o  = m_sel_i;
	assign s_data_o = m_data_i;
	assign s_adr_o  = m_adr_i[`SLAVE_ADDR_WIDTH-1:0];

	// Remember where the request went, for the response cycle
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			resp_valid <= 1'b0;
			resp_sel   <= SLAVE_NONE;
		end else begin
			resp_valid <= req_valid;
			resp_sel   <= req_sel;
		end
	end

	always_comb begin
		resp_ack = 1'b0;
		m_data_o = '0;
		case (resp_sel)
			SLAVE_MEM0: begin
				resp_ack = mem0_ack_i;
				m_data_o = mem0_data_i;
			end
			SLAVE_MEM1: begin
				resp_ack = mem1_ack_i;
				m_data_o = mem1_data_i;
			end
			SLAVE_GPIO: begin
				resp_ack = gpio_ack_i;
				m_data_o = gpio_data_i;
			end
			default: begin
				resp_ack = 1'b0;
			end
		endcase
	end

	assign m_ack_o = resp_valid & resp_ack;
	// Unmapped region gets an error in place of the ack
	assign m_error_o = resp_valid & (resp_sel == SLAVE_NONE);

endmodule

// File: logic/experiar_soc_top.sv
`timescale 1ns/1ps

`include "experiar_config.svh"

module experiar_soc_top (
	input  logic                          wb_clk_i,
	input  logic                          rst_n_i,

	// External Wishbone master
	input  logic                          wb_cyc_i,
	input  logic                          wb_stb_i,
	input  logic                          wb_we_i,
	input  experiar_pkg::wb_sel_t         wb_sel_i,
	input  experiar_pkg::wb_data_t        wb_data_i,
	input  experiar_pkg::wb_addr_t        wb_adr_i,
	output logic                          wb_ack_o,
	output logic                          wb_error_o,
	output experiar_pkg::wb_data_t        wb_data_o,

	// Pads
	input  experiar_pkg::gpio_t           gpio_in_i,
	output experiar_pkg::gpio_t           gpio_out_o,
	output experiar_pkg::gpio_t           gpio_oeb_o,

	input  logic [`CARAVEL_IRQ_WIDTH-1:0] caravel_irq_i,
	output logic [`CARAVEL_IRQ_WIDTH:0]   irq_o
);

	import experiar_pkg::*;

	logic        mem0_stb;
	logic        mem0_ack;
	wb_data_t    mem0_data;
	logic        mem1_stb;
	logic        mem1_ack;
	wb_data_t    mem1_data;
	logic        gpio_stb;
	logic        gpio_ack;
	wb_data_t    gpio_data;
	logic        gpio_irq;

	// Shared request fields
	logic        s_we;
	wb_sel_t     s_sel;
	wb_data_t    s_data;
	slave_addr_t s_adr;

	wishbone_interconnect u_interconnect (
		.wb_clk_i    (wb_clk_i),
		.rst_n_i     (rst_n_i),
		.m_cyc_i     (wb_cyc_i),
		.m_stb_i     (wb_stb_i),
		.m_we_i      (wb_we_i),
		.m_sel_i     (wb_sel_i),
		.m_data_i    (wb_data_i),
		.m_adr_i     (wb_adr_i),
		.m_ack_o     (wb_ack_o),
		.m_error_o   (wb_error_o),
		.m_data_o    (wb_data_o),
		.mem0_stb_o  (mem0_stb),
		.mem0_ack_i  (mem0_ack),
		.mem0_data_i (mem0_data),
		.mem1_stb_o  (mem1_stb),
		.mem1_ack_i  (mem1_ack),
		.mem1_data_i (mem1_data),
		.gpio_stb_o  (gpio_stb),
		.gpio_ack_i  (gpio_ack),
		.gpio_data_i (gpio_data),
		.s_we_o      (s_we),
		.s_sel_o     (s_sel),
		.s_data_o    (s_data),
		.s_adr_o     (s_adr)
	);

	local_memory u_core0_memory (
		.wb_clk_i  (wb_clk_i),
		.rst_n_i   (rst_n_i),
		.wb_stb_i  (mem0_stb),
		.wb_we_i   (s_we),
		.wb_sel_i  (s_sel),
		.wb_data_i (s_data),
		.wb_adr_i  (s_adr),
		.wb_ack_o  (mem0_ack),
		.wb_data_o (mem0_data)
	);

	local_memory u_core1_memory (
		.wb_clk_i  (wb_clk_i),
		.rst_n_i   (rst_n_i),
		.wb_stb_i  (mem1_stb),
		.wb_we_i   (s_we),
		.wb_sel_i  (s_sel),
		.wb_data_i (s_data),
		.wb_adr_i  (s_adr),
		.wb_ack_o  (mem1_ack),
		.wb_data_o (mem1_data)
	);

	gpio_peripheral u_gpio (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.wb_stb_i   (gpio_stb),
		.wb_we_i    (s_we),
		.wb_sel_i   (s_sel),
		.wb_data_i  (s_data),
		.wb_adr_i   (s_adr),
		.gpio_in_i  (gpio_in_i),
		.wb_ack_o   (gpio_ack),
		.wb_data_o  (gpio_data),
		.gpio_out_o (gpio_out_o),
		.gpio_oeb_o (gpio_oeb_o),
		.gpio_irq_o (gpio_irq)
	);

	// Caravel lines sit above the GPIO interrupt
	assign irq_o = {caravel_irq_i, gpio_irq};

endmodule

// File: testbench/experiar_soc_tb.sv
`timescale 1ns/1ps

`include "experiar_config.svh"

module experiar_soc_tb;

	import experiar_pkg::*;

	localparam int MAX_ENTRIES = 64;
	localparam int CLK_PERIOD  = 40;

	logic clk;
	logic rst_n;
	logic cyc;
	logic stb;
	logic we;
	wb_sel_t sel;
	wb_data_t wdata;
	wb_addr_t adr;
	logic ack;
	logic err;
	wb_data_t rdata;
	gpio_t gpio_in;
	gpio_t gpio_out;
	gpio_t gpio_oeb;
	logic [`CARAVEL_IRQ_WIDTH-1:0] caravel_irq;
	logic [`CARAVEL_IRQ_WIDTH:0] irq;

	// Stimulus table
	bit t_we [MAX_ENTRIES];
	wb_addr_t t_adr [MAX_ENTRIES];
	wb_sel_t t_sel [MAX_ENTRIES];
	wb_data_t t_wdata [MAX_ENTRIES];
	gpio_t t_gin [MAX_ENTRIES];
	logic [`CARAVEL_IRQ_WIDTH-1:0] t_cirq [MAX_ENTRIES];
	int t_idle [MAX_ENTRIES];
	bit t_err [MAX_ENTRIES];
	int n_entries = 0;
	int seed = 37;
	int cycle = 0;

	// Reference model state
	logic [7:0] mem_model [int];
	gpio_t model_out = '0;
	gpio_t model_oe = '0;
	gpio_t model_pending = '0;
	gpio_t model_gin = '0;

	// Responses still owed by the DUT
	int exp_cycle_q [$];
	bit exp_err_q [$];
	bit exp_read_q [$];
	wb_data_t exp_data_q [$];

	experiar_soc_top u_experiar_soc_top (
		.wb_clk_i      (clk),
		.rst_n_i       (rst_n),
		.wb_cyc_i      (cyc),
		.wb_stb_i      (stb),
		.wb_we_i       (we),
		.wb_sel_i      (sel),
		.wb_data_i     (wdata),
		.wb_adr_i      (adr),
		.wb_ack_o      (ack),
		.wb_error_o    (err),
		.wb_data_o     (rdata),
		.gpio_in_i     (gpio_in),
		.gpio_out_o    (gpio_out),
		.gpio_oeb_o    (gpio_oeb),
		.caravel_irq_i (caravel_irq),
		.irq_o         (irq)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic report_error(string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic check_value(string name, wb_data_t exp, wb_data_t got);
		assert (got === exp) else begin
			report_error($sformatf("MISMATCH at %0d ns: %s expected 0x%08h got 0x%08h",
				$time, name, exp, got));
		end
	endtask

	task automatic add_entry(bit e_we, wb_addr_t e_adr, wb_sel_t e_sel, wb_data_t e_wdata,
		gpio_t e_gin, logic [`CARAVEL_IRQ_WIDTH-1:0] e_cirq, int e_idle, bit e_err);
		t_we[n_entries] = e_we;
		t_adr[n_entries] = e_adr;
		t_sel[n_entries] = e_sel;
		t_wdata[n_entries] = e_wdata;
		t_gin[n_entries] = e_gin;
		t_cirq[n_entries] = e_cirq;
		t_idle[n_entries] = e_idle;
		t_err[n_entries] = e_err;
		n_entries++;
	endtask

	// Byte address inside the 4 KB of one local memory
	function automatic int mem_key(wb_addr_t a);
		return int'(a[27:24]) * 4096 + int'(a[11:2]) * 4;
	endfunction

	function automatic wb_data_t mem_read(wb_addr_t a);
		wb_data_t d;
		for (int b = 0; b < 4; b++) begin
			d[8*b +: 8] = mem_model.exists(mem_key(a) + b) ? mem_model[mem_key(a) + b] : 8'hxx;
		end
		return d;
	endfunction

	task automatic mem_write(wb_addr_t a, wb_sel_t s, wb_data_t d);
		for (int b = 0; b < 4; b++) begin
			if (s[b]) begin
				mem_model[mem_key(a) + b] = d[8*b +: 8];
			end
		end
	endtask

	function automatic wb_data_t gpio_read(wb_addr_t a);
		case (a[7:0])
			`GPIO_OUT_OFS: return model_out;
			`GPIO_OE_OFS:  return model_oe;
			`GPIO_IN_OFS:  return model_gin;
			`GPIO_IRQ_OFS: return model_pending;
			default:       return '0;
		endcase
	endfunction

	task automatic gpio_write(wb_addr_t a, wb_sel_t s, wb_data_t d);
		wb_data_t mask;
		for (int b = 0; b < 4; b++) begin
			mask[8*b +: 8] = {8{s[b]}};
		end
		case (a[7:0])
			`GPIO_OUT_OFS: model_out = (model_out & ~mask) | (d & mask);
			`GPIO_OE_OFS:  model_oe = (model_oe & ~mask) | (d & mask);
			`GPIO_IRQ_OFS: model_pending = model_pending & ~(d & mask);
			default: ;
		endcase
	endtask

	task automatic check_outputs();
		check_value("gpio_out_o", model_out, gpio_out);
		check_value("gpio_oeb_o", ~model_oe, gpio_oeb);
		check_value("irq_o[0]", 32'(|model_pending), 32'(irq[0]));
	endtask

	task automatic build_table();
		gpio_t gin_a;
		// Full words at the same offsets in both memories
		add_entry(1'b1, 28'h0000010, 4'hF, $random(seed), '0, 4'h0, 0, 1'b0);
		add_entry(1'b1, 28'h1000010, 4'hF, $random(seed), '0, 4'h1, 1, 1'b0);
		add_entry(1'b1, 28'h0000020, 4'hF, $random(seed), '0, 4'h2, 0, 1'b0);
		add_entry(1'b1, 28'h1000020, 4'hF, $random(seed), '0, 4'h3, 2, 1'b0);
		add_entry(1'b0, 28'h0000010, 4'hF, '0, '0, 4'h4, 1, 1'b0);
		add_entry(1'b0, 28'h1000010, 4'hF, '0, '0, 4'h5, 1, 1'b0);
		// Byte masks, bank 1 reached through address bit 11
		add_entry(1'b1, 28'h0000040, 4'hF, $random(seed), '0, 4'h6, 0, 1'b0);
		add_entry(1'b1, 28'h0000840, 4'hF, $random(seed), '0, 4'h7, 0, 1'b0);
		add_entry(1'b1, 28'h0000040, 4'h2, $random(seed), '0, 4'h8, 0, 1'b0);
		add_entry(1'b1, 28'h0000840, 4'h9, $random(seed), '0, 4'h9, 1, 1'b0);
		add_entry(1'b1, 28'h1000840, 4'hF, $random(seed), '0, 4'hA, 0, 1'b0);
		add_entry(1'b0, 28'h0000040, 4'hF, '0, '0, 4'hB, 1, 1'b0);
		add_entry(1'b0, 28'h0000840, 4'hF, '0, '0, 4'hC, 0, 1'b0);
		add_entry(1'b0, 28'h1000840, 4'hF, '0, '0, 4'hD, 2, 1'b0);
		// Back-to-back reads across both memories
		add_entry(1'b0, 28'h0000020, 4'hF, '0, '0, 4'hE, 0, 1'b0);
		add_entry(1'b0, 28'h1000020, 4'hF, '0, '0, 4'hF, 0, 1'b0);
		add_entry(1'b0, 28'h0000840, 4'hF, '0, '0, 4'h0, 0, 1'b0);
		add_entry(1'b0, 28'h1000010, 4'hF, '0, '0, 4'h1, 3, 1'b0);
		// Unmapped regions answer with an error
		add_entry(1'b1, 28'h2000010, 4'hF, $random(seed), '0, 4'h2, 0, 1'b1);
		add_entry(1'b0, 28'h0000010, 4'hF, '0, '0, 4'h3, 0, 1'b0);
		add_entry(1'b0, 28'hF000040, 4'hF, '0, '0, 4'h4, 1, 1'b1);
		add_entry(1'b1, 28'hF000040, 4'hF, $random(seed), '0, 4'h5, 0, 1'b1);
		add_entry(1'b0, 28'h0000040, 4'hF, '0, '0, 4'h6, 1, 1'b0);
		// GPIO output and enable registers
		add_entry(1'b1, 28'h3000000, 4'hF, $random(seed), '0, 4'h7, 0, 1'b0);
		add_entry(1'b1, 28'h3000004, 4'hF, $random(seed), '0, 4'h8, 1, 1'b0);
		add_entry(1'b1, 28'h3000004, 4'h1, $random(seed), '0, 4'h9, 0, 1'b0);
		add_entry(1'b1, 28'h3000008, 4'hF, $random(seed), '0, 4'hA, 0, 1'b0);
		add_entry(1'b0, 28'h3000000, 4'hF, '0, '0, 4'hB, 0, 1'b0);
		add_entry(1'b0, 28'h3000004, 4'hF, '0, '0, 4'hC, 1, 1'b0);
		// Inputs, edges and pending flags
		gin_a = $random(seed);
		add_entry(1'b0, 28'h3000000, 4'hF, '0, gin_a, 4'hD, 3, 1'b0);
		add_entry(1'b0, 28'h3000008, 4'hF, '0, gin_a, 4'hE, 0, 1'b0);
		add_entry(1'b0, 28'h300000C, 4'hF, '0, gin_a, 4'hF, 0, 1'b0);
		add_entry(1'b1, 28'h300000C, 4'hF, 32'hFFFFFFFF, gin_a, 4'h0, 0, 1'b0);
		add_entry(1'b0, 28'h300000C, 4'hF, '0, gin_a, 4'h1, 1, 1'b0);
		add_entry(1'b0, 28'h3000008, 4'hF, '0, ~gin_a, 4'h2, 3, 1'b0);
		add_entry(1'b1, 28'h300000C, 4'h1, 32'hFFFFFFFF, ~gin_a, 4'h3, 0, 1'b0);
		add_entry(1'b0, 28'h300000C, 4'hF, '0, ~gin_a, 4'h4, 0, 1'b0);
		add_entry(1'b1, 28'h300000C, 4'hF, 32'hFFFFFFFF, ~gin_a, 4'h5, 1, 1'b0);
		// Falling edges leave the flags alone
		add_entry(1'b0, 28'h300000C, 4'hF, '0, 32'h00000000, 4'h6, 4, 1'b0);
		add_entry(1'b0, 28'h300000C, 4'hF, '0, 32'h00000001, 4'h7, 3, 1'b0);
		add_entry(1'b1, 28'h300000C, 4'hF, 32'h00000001, 32'h00000001, 4'h8, 1, 1'b0);
		add_entry(1'b0, 28'h3000008, 4'hF, '0, 32'h00000001, 4'h9, 2, 1'b0);
	endtask

	task automatic apply_entry(int i);
		wb_data_t expected;
		region_t region;
		@(posedge clk);
		#2;
		check_outputs();
		cyc = 1'b1;
		stb = 1'b1;
		we = t_we[i];
		sel = t_sel[i];
		wdata = t_wdata[i];
		adr = t_adr[i];
		gpio_in = t_gin[i];
		caravel_irq = t_cirq[i];
		region = t_adr[i][27:24];
		expected = '0;
		if (!t_err[i]) begin
			if (region == `REGION_GPIO) begin
				if (t_we[i]) gpio_write(t_adr[i], t_sel[i], t_wdata[i]);
				else expected = gpio_read(t_adr[i]);
			end else begin
				if (t_we[i]) mem_write(t_adr[i], t_sel[i], t_wdata[i]);
				else expected = mem_read(t_adr[i]);
			end
		end
		exp_cycle_q.push_back(cycle + 1);
		exp_err_q.push_back(t_err[i]);
		exp_read_q.push_back(!t_we[i]);
		exp_data_q.push_back(expected);
		// New input level reaches the pending flags during the idle cycles
		model_pending = model_pending | (t_gin[i] & ~model_gin);
		model_gin = t_gin[i];
		repeat (t_idle[i]) begin
			@(posedge clk);
			#2;
			cyc = 1'b0;
			stb = 1'b0;
		end
	endtask

	// Response and interrupt checks, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n) begin
			check_value("irq_o[4:1]", 32'(caravel_irq), 32'(irq[`CARAVEL_IRQ_WIDTH:1]));
			if (exp_cycle_q.size() != 0 && exp_cycle_q[0] == cycle) begin
				check_value("wb_ack_o", 32'(!exp_err_q[0]), 32'(ack));
				check_value("wb_error_o", 32'(exp_err_q[0]), 32'(err));
				if (exp_read_q[0] && !exp_err_q[0]) begin
					check_value("wb_data_o", exp_data_q[0], rdata);
				end
				void'(exp_cycle_q.pop_front());
				void'(exp_err_q.pop_front());
				void'(exp_read_q.pop_front());
				void'(exp_data_q.pop_front());
			end else begin
				check_value("wb_ack_o", 32'h0, 32'(ack));
				check_value("wb_error_o", 32'h0, 32'(err));
			end
		end
	end

	initial begin
		#1;
		#(n_entries * 12 * CLK_PERIOD + 2000);
		report_error("Timeout: the test sequence did not complete in time");
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		sel = '0;
		wdata = '0;
		adr = '0;
		gpio_in = '0;
		caravel_irq = '0;
		build_table();
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int i = 0; i < n_entries; i++) begin
			apply_entry(i);
		end
		@(posedge clk);
		#2;
		cyc = 1'b0;
		stb = 1'b0;
		while (exp_cycle_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (2) @(posedge clk);
		#2;
		check_outputs();
		$display("Everything OK");
		$finish;
	end

endmodule

// File: sim.f
+incdir+logic
logic/experiar_pkg.sv
logic/sram_32x512.sv
logic/local_memory.sv
logic/gpio_peripheral.sv
logic/wishbone_interconnect.sv
logic/experiar_soc_top.sv
testbench/experiar_soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module experiar_soc_tb -o experiar_soc_sim

./obj_dir/experiar_soc_sim 2>&1 | tee sim.log

if grep -qx "Everything OK" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
